// ==== common/mem_pkg.sv ====
package mem_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int LEN_WIDTH  = 8;
    localparam int ID_WIDTH   = 4;
    localparam int RESP_WIDTH = 2;
    localparam int SRAM_DEPTH = 256;

    // Word index into the SRAM, taken from address bits 10:3
    localparam int IDX_WIDTH = $clog2(SRAM_DEPTH);
    localparam int WORD_LSB  = $clog2(DATA_WIDTH / 8);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [LEN_WIDTH-1:0]  len_t;   // Beats minus one
    typedef logic [ID_WIDTH-1:0]   id_t;
    typedef logic [RESP_WIDTH-1:0] resp_t;
    typedef logic [1:0]            burst_t;
    typedef logic [IDX_WIDTH-1:0]  idx_t;

    localparam burst_t BURST_INCR = 2'b01;
    localparam resp_t  RESP_OKAY  = 2'b00;

    // Read owner tags carried on AR/R
    localparam id_t ID_IFU = 4'd1;
    localparam id_t ID_LSU = 4'd2;

    typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} w_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} r_state_e;

    typedef enum logic [1:0] {SR_IDLE, SR_ADDR, SR_DATA} sram_r_state_e;
    typedef enum logic [1:0] {SW_IDLE, SW_ADDR, SW_DATA, SW_RESP} sram_w_state_e;

endpackage

// ==== rtl/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter (
    input  logic            aclk,
    input  logic            areset_n,

    input  logic            ifu_r_valid_i,
    input  mem_pkg::addr_t  ifu_r_addr_i,
    input  mem_pkg::len_t   ifu_r_len_i,
    output logic            ifu_r_ready_o,
    output mem_pkg::data_t  ifu_r_data_o,
    output logic            ifu_r_last_o,

    input  logic            lsu_r_valid_i,
    input  mem_pkg::addr_t  lsu_r_addr_i,
    input  mem_pkg::len_t   lsu_r_len_i,
    output logic            lsu_r_ready_o,
    output mem_pkg::data_t  lsu_r_data_o,
    output logic            lsu_r_last_o,

    output logic            bus_r_valid_o,
    output mem_pkg::addr_t  bus_r_addr_o,
    output mem_pkg::len_t   bus_r_len_o,
    output mem_pkg::id_t    bus_r_id_o,
    input  logic            bus_r_ready_i,
    input  mem_pkg::data_t  bus_r_data_i,
    input  logic            bus_r_last_i
);

    logic busy;
    logic owner;        // 0 ifu, 1 lsu; keeps its value after release as the last winner
    logic grant_lsu;

    // Round robin only decides when both are waiting
    always_comb begin
        if (ifu_r_valid_i && lsu_r_valid_i) begin
            grant_lsu = ~owner;
        end else begin
            grant_lsu = lsu_r_valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end else if (busy) begin
            if (bus_r_last_i) begin
                busy <= 1'b0;
            end
        end else if (ifu_r_valid_i || lsu_r_valid_i) begin
            busy  <= 1'b1;
            owner <= grant_lsu;
        end
    end

    assign bus_r_valid_o = busy & (owner ? lsu_r_valid_i : ifu_r_valid_i);
    assign bus_r_addr_o  = owner ? lsu_r_addr_i : ifu_r_addr_i;
    assign bus_r_len_o   = owner ? lsu_r_len_i : ifu_r_len_i;
    assign bus_r_id_o    = owner ? mem_pkg::ID_LSU : mem_pkg::ID_IFU;

    // Beats go only to the current owner
    assign ifu_r_ready_o = busy & ~owner & bus_r_ready_i;
    assign ifu_r_last_o  = busy & ~owner & bus_r_last_i;
    assign ifu_r_data_o  = bus_r_data_i;

    assign lsu_r_ready_o = busy & owner & bus_r_ready_i;
    assign lsu_r_last_o  = busy & owner & bus_r_last_i;
    assign lsu_r_data_o  = bus_r_data_i;

endmodule

// ==== axi_master/axi_master.sv ====
`timescale 1ns/1ps

module axi_master (
    input  logic              aclk,
    input  logic              areset_n,

    input  logic              cpu_r_valid_i,
    input  mem_pkg::addr_t    cpu_r_addr_i,
    input  mem_pkg::len_t     cpu_r_len_i,
    input  mem_pkg::id_t      cpu_r_id_i,
    output logic              cpu_r_ready_o,
    output mem_pkg::data_t    cpu_r_data_o,
    output logic              cpu_r_last_o,

    input  logic              cpu_w_valid_i,
    input  mem_pkg::addr_t    cpu_w_addr_i,
    input  mem_pkg::len_t     cpu_w_len_i,
    input  mem_pkg::data_t    cpu_w_data_i,
    output logic              cpu_w_ready_o,
    output logic              cpu_w_last_o,

    output logic              axi_aw_valid_o,
    input  logic              axi_aw_ready_i,
    output mem_pkg::addr_t    axi_aw_addr_o,
    output mem_pkg::id_t      axi_aw_id_o,
    output mem_pkg::len_t     axi_aw_len_o,
    output mem_pkg::burst_t   axi_aw_burst_o,
    output logic              axi_w_valid_o,
    input  logic              axi_w_ready_i,
    output mem_pkg::data_t    axi_w_data_o,
    output logic              axi_w_last_o,
    output logic              axi_b_ready_o,
    input  logic              axi_b_valid_i,
    input  mem_pkg::resp_t    axi_b_resp_i,

    output logic              axi_ar_valid_o,
    input  logic              axi_ar_ready_i,
    output mem_pkg::addr_t    axi_ar_addr_o,
    output mem_pkg::id_t      axi_ar_id_o,
    output mem_pkg::len_t     axi_ar_len_o,
    output mem_pkg::burst_t   axi_ar_burst_o,
    output logic              axi_r_ready_o,
    input  logic              axi_r_valid_i,
    input  mem_pkg::data_t    axi_r_data_i,
    input  logic              axi_r_last_i,
    input  mem_pkg::id_t      axi_r_id_i,
    input  mem_pkg::resp_t    axi_r_resp_i
);

    mem_pkg::w_state_e w_state;
    mem_pkg::r_state_e r_state;
    mem_pkg::len_t     w_cnt;
    mem_pkg::addr_t    aw_addr;
    mem_pkg::len_t     aw_len;
    mem_pkg::addr_t    ar_addr;
    mem_pkg::len_t     ar_len;
    mem_pkg::id_t      ar_id;
    logic              w_beat;
    logic              r_beat;

    // Request fields are captured as the FSMs leave IDLE
    always_ff @(posedge aclk) begin
        if (w_state == mem_pkg::W_IDLE && cpu_w_valid_i) begin
            aw_addr <= cpu_w_addr_i;
            aw_len  <= cpu_w_len_i;
        end
        if (r_state == mem_pkg::R_IDLE && cpu_r_valid_i) begin
            ar_addr <= cpu_r_addr_i;
            ar_len  <= cpu_r_len_i;
            ar_id   <= cpu_r_id_i;
        end
    end

    assign axi_aw_valid_o = (w_state == mem_pkg::W_ADDR);
    assign axi_aw_addr_o  = aw_addr;
    assign axi_aw_id_o    = mem_pkg::ID_LSU;
    assign axi_aw_len_o   = aw_len;
    assign axi_aw_burst_o = mem_pkg::BURST_INCR;

    assign axi_w_valid_o  = (w_state == mem_pkg::W_DATA);
    assign axi_w_data_o   = cpu_w_data_i;
    assign axi_w_last_o   = axi_w_valid_o & (w_cnt == aw_len);
    assign axi_b_ready_o  = (w_state == mem_pkg::W_DATA) | (w_state == mem_pkg::W_RESP);

    assign w_beat         = axi_w_valid_o & axi_w_ready_i;
    assign cpu_w_ready_o  = w_beat;                         // Requester moves to next beat
    assign cpu_w_last_o   = axi_b_valid_i & axi_b_ready_o;

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            w_state <= mem_pkg::W_IDLE;
            w_cnt   <= '0;
        end else begin
            case (w_state)
                mem_pkg::W_IDLE: begin
                    w_cnt <= '0;
                    if (cpu_w_valid_i) w_state <= mem_pkg::W_ADDR;
                end
                mem_pkg::W_ADDR: begin
                    if (axi_aw_ready_i) w_state <= mem_pkg::W_DATA;
                end
                mem_pkg::W_DATA: begin
                    if (w_beat) begin
                        if (axi_w_last_o) begin
                            w_state <= mem_pkg::W_RESP;
                        end else begin
                            w_cnt <= w_cnt + 1'b1;
                        end
                    end
                end
                mem_pkg::W_RESP: begin
                    if (axi_b_valid_i) w_state <= mem_pkg::W_IDLE;
                end
                default: w_state <= mem_pkg::W_IDLE;
            endcase
        end
    end

    assign axi_ar_valid_o = (r_state == mem_pkg::R_ADDR);
    assign axi_ar_addr_o  = ar_addr;
    assign axi_ar_id_o    = ar_id;
    assign axi_ar_len_o   = ar_len;
    assign axi_ar_burst_o = mem_pkg::BURST_INCR;
    assign axi_r_ready_o  = (r_state == mem_pkg::R_DATA);

    assign r_beat         = axi_r_valid_i & axi_r_ready_o & (axi_r_id_i == ar_id);
    assign cpu_r_ready_o  = r_beat;
    assign cpu_r_data_o   = axi_r_data_i;
    assign cpu_r_last_o   = r_beat & axi_r_last_i;

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            r_state <= mem_pkg::R_IDLE;
        end else begin
            case (r_state)
                mem_pkg::R_IDLE: if (cpu_r_valid_i) r_state <= mem_pkg::R_ADDR;
                mem_pkg::R_ADDR: if (axi_ar_ready_i) r_state <= mem_pkg::R_DATA;
                mem_pkg::R_DATA: if (cpu_r_last_o) r_state <= mem_pkg::R_IDLE;
                default:         r_state <= mem_pkg::R_IDLE;
            endcase
        end
    end

endmodule

// ==== axi_sram/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram (
    input  logic              aclk,
    input  logic              areset_n,

    input  logic              axi_aw_valid_i,
    output logic              axi_aw_ready_o,
    input  mem_pkg::addr_t    axi_aw_addr_i,
    input  mem_pkg::id_t      axi_aw_id_i,
    input  mem_pkg::len_t     axi_aw_len_i,
    input  mem_pkg::burst_t   axi_aw_burst_i,
    input  logic              axi_w_valid_i,
    output logic              axi_w_ready_o,
    input  mem_pkg::data_t    axi_w_data_i,
    input  logic              axi_w_last_i,
    input  logic              axi_b_ready_i,
    output logic              axi_b_valid_o,
    output mem_pkg::resp_t    axi_b_resp_o,

    input  logic              axi_ar_valid_i,
    output logic              axi_ar_ready_o,
    input  mem_pkg::addr_t    axi_ar_addr_i,
    input  mem_pkg::id_t      axi_ar_id_i,
    input  mem_pkg::len_t     axi_ar_len_i,
    input  mem_pkg::burst_t   axi_ar_burst_i,
    input  logic              axi_r_ready_i,
    output logic              axi_r_valid_o,
    output mem_pkg::data_t    axi_r_data_o,
    output logic              axi_r_last_o,
    output mem_pkg::id_t      axi_r_id_o,
    output mem_pkg::resp_t    axi_r_resp_o
);

    mem_pkg::data_t         mem [mem_pkg::SRAM_DEPTH];

    mem_pkg::sram_w_state_e w_state;
    mem_pkg::sram_r_state_e r_state;
    mem_pkg::idx_t          w_idx;
    mem_pkg::idx_t          r_idx;
    mem_pkg::len_t          w_cnt;
    mem_pkg::len_t          r_cnt;
    mem_pkg::len_t          aw_len;
    mem_pkg::len_t          ar_len;
    mem_pkg::burst_t        aw_burst;
    mem_pkg::burst_t        ar_burst;
    mem_pkg::id_t           r_id;
    logic                   w_beat;
    logic                   w_done;
    logic                   r_beat;

    assign axi_aw_ready_o = (w_state == mem_pkg::SW_ADDR);
    assign axi_w_ready_o  = (w_state == mem_pkg::SW_DATA);
    assign axi_b_valid_o  = (w_state == mem_pkg::SW_RESP);
    assign axi_b_resp_o   = mem_pkg::RESP_OKAY;

    assign w_beat = axi_w_valid_i & axi_w_ready_o;
    assign w_done = axi_w_last_i | (w_cnt == aw_len);       // Counted end also closes the burst

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            w_state <= mem_pkg::SW_IDLE;
            w_cnt   <= '0;
        end else begin
            case (w_state)
                mem_pkg::SW_IDLE: if (axi_aw_valid_i) w_state <= mem_pkg::SW_ADDR;
                mem_pkg::SW_ADDR: begin
                    w_cnt <= '0;
                    if (axi_aw_valid_i) w_state <= mem_pkg::SW_DATA;
                end
                mem_pkg::SW_DATA: begin
                    if (w_beat) begin
                        w_cnt <= w_cnt + 1'b1;
                        if (w_done) w_state <= mem_pkg::SW_RESP;
                    end
                end
                mem_pkg::SW_RESP: if (axi_b_ready_i) w_state <= mem_pkg::SW_IDLE;
                default:          w_state <= mem_pkg::SW_IDLE;
            endcase
        end
    end

    // Storage and write pointer
    always_ff @(posedge aclk) begin
        if (axi_aw_valid_i && axi_aw_ready_o) begin
            w_idx    <= axi_aw_addr_i[mem_pkg::WORD_LSB +: mem_pkg::IDX_WIDTH];
            aw_len   <= axi_aw_len_i;
            aw_burst <= axi_aw_burst_i;
        end else if (w_beat) begin
            mem[w_idx] <= axi_w_data_i;
            if (aw_burst == mem_pkg::BURST_INCR) w_idx <= w_idx + 1'b1;  // Wraps at the top
        end
    end

    assign axi_ar_ready_o = (r_state == mem_pkg::SR_ADDR);
    assign axi_r_valid_o  = (r_state == mem_pkg::SR_DATA);
    assign axi_r_data_o   = mem[r_idx];
    assign axi_r_last_o   = axi_r_valid_o & (r_cnt == ar_len);
    assign axi_r_id_o     = r_id;
    assign axi_r_resp_o   = mem_pkg::RESP_OKAY;

    assign r_beat = axi_r_valid_o & axi_r_ready_i;

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            r_state <= mem_pkg::SR_IDLE;
            r_cnt   <= '0;
        end else begin
            case (r_state)
                mem_pkg::SR_IDLE: if (axi_ar_valid_i) r_state <= mem_pkg::SR_ADDR;
                mem_pkg::SR_ADDR: begin
                    r_cnt <= '0;
                    if (axi_ar_valid_i) r_state <= mem_pkg::SR_DATA;
                end
                mem_pkg::SR_DATA: begin
                    if (r_beat) begin
                        r_cnt <= r_cnt + 1'b1;
                        if (axi_r_last_o) r_state <= mem_pkg::SR_IDLE;
                    end
                end
                default: r_state <= mem_pkg::SR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (axi_ar_valid_i && axi_ar_ready_o) begin
            r_idx    <= axi_ar_addr_i[mem_pkg::WORD_LSB +: mem_pkg::IDX_WIDTH];
            ar_len   <= axi_ar_len_i;
            ar_burst <= axi_ar_burst_i;
            r_id     <= axi_ar_id_i;
        end else if (r_beat && ar_burst == mem_pkg::BURST_INCR) begin
            r_idx <= r_idx + 1'b1;
        end
    end

endmodule

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic            aclk,
    input  logic            areset_n,

    input  logic            ifu_r_valid_i,
    input  mem_pkg::addr_t  ifu_r_addr_i,
    input  mem_pkg::len_t   ifu_r_len_i,
    output logic            ifu_r_ready_o,
    output mem_pkg::data_t  ifu_r_data_o,
    output logic            ifu_r_last_o,

    input  logic            lsu_r_valid_i,
    input  mem_pkg::addr_t  lsu_r_addr_i,
    input  mem_pkg::len_t   lsu_r_len_i,
    output logic            lsu_r_ready_o,
    output mem_pkg::data_t  lsu_r_data_o,
    output logic            lsu_r_last_o,

    input  logic            lsu_w_valid_i,
    input  mem_pkg::addr_t  lsu_w_addr_i,
    input  mem_pkg::len_t   lsu_w_len_i,
    input  mem_pkg::data_t  lsu_w_data_i,
    output logic            lsu_w_ready_o,
    output logic            lsu_w_last_o
);

    // Shared read port between arbiter and bridge
    logic            bus_r_valid;
    mem_pkg::addr_t  bus_r_addr;
    mem_pkg::len_t   bus_r_len;
    mem_pkg::id_t    bus_r_id;
    logic            bus_r_ready;
    mem_pkg::data_t  bus_r_data;
    logic            bus_r_last;

    logic            aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
    mem_pkg::addr_t  aw_addr, ar_addr;
    mem_pkg::id_t    aw_id, ar_id, r_id;
    mem_pkg::len_t   aw_len, ar_len;
    mem_pkg::burst_t aw_burst, ar_burst;
    mem_pkg::data_t  w_data, r_data;
    mem_pkg::resp_t  b_resp, r_resp;
    logic            ar_valid, ar_ready, r_valid, r_ready, r_last;

    read_arbiter u_read_arbiter (
        .aclk          (aclk),          .areset_n      (areset_n),
        .ifu_r_valid_i (ifu_r_valid_i), .ifu_r_addr_i  (ifu_r_addr_i),
        .ifu_r_len_i   (ifu_r_len_i),   .ifu_r_ready_o (ifu_r_ready_o),
        .ifu_r_data_o  (ifu_r_data_o),  .ifu_r_last_o  (ifu_r_last_o),
        .lsu_r_valid_i (lsu_r_valid_i), .lsu_r_addr_i  (lsu_r_addr_i),
        .lsu_r_len_i   (lsu_r_len_i),   .lsu_r_ready_o (lsu_r_ready_o),
        .lsu_r_data_o  (lsu_r_data_o),  .lsu_r_last_o  (lsu_r_last_o),
        .bus_r_valid_o (bus_r_valid),   .bus_r_addr_o  (bus_r_addr),
        .bus_r_len_o   (bus_r_len),     .bus_r_id_o    (bus_r_id),
        .bus_r_ready_i (bus_r_ready),   .bus_r_data_i  (bus_r_data),
        .bus_r_last_i  (bus_r_last)
    );

    axi_master u_axi_master (
        .aclk           (aclk),          .areset_n       (areset_n),
        .cpu_r_valid_i  (bus_r_valid),   .cpu_r_addr_i   (bus_r_addr),
        .cpu_r_len_i    (bus_r_len),     .cpu_r_id_i     (bus_r_id),
        .cpu_r_ready_o  (bus_r_ready),   .cpu_r_data_o   (bus_r_data),
        .cpu_r_last_o   (bus_r_last),
        .cpu_w_valid_i  (lsu_w_valid_i), .cpu_w_addr_i   (lsu_w_addr_i),
        .cpu_w_len_i    (lsu_w_len_i),   .cpu_w_data_i   (lsu_w_data_i),
        .cpu_w_ready_o  (lsu_w_ready_o), .cpu_w_last_o   (lsu_w_last_o),
        .axi_aw_valid_o (aw_valid),      .axi_aw_ready_i (aw_ready),
        .axi_aw_addr_o  (aw_addr),       .axi_aw_id_o    (aw_id),
        .axi_aw_len_o   (aw_len),        .axi_aw_burst_o (aw_burst),
        .axi_w_valid_o  (w_valid),       .axi_w_ready_i  (w_ready),
        .axi_w_data_o   (w_data),        .axi_w_last_o   (w_last),
        .axi_b_ready_o  (b_ready),       .axi_b_valid_i  (b_valid),
        .axi_b_resp_i   (b_resp),
        .axi_ar_valid_o (ar_valid),      .axi_ar_ready_i (ar_ready),
        .axi_ar_addr_o  (ar_addr),       .axi_ar_id_o    (ar_id),
        .axi_ar_len_o   (ar_len),        .axi_ar_burst_o (ar_burst),
        .axi_r_ready_o  (r_ready),       .axi_r_valid_i  (r_valid),
        .axi_r_data_i   (r_data),        .axi_r_last_i   (r_last),
        .axi_r_id_i     (r_id),          .axi_r_resp_i   (r_resp)
    );

    axi_sram u_axi_sram (
        .aclk           (aclk),          .areset_n       (areset_n),
        .axi_aw_valid_i (aw_valid),      .axi_aw_ready_o (aw_ready),
        .axi_aw_addr_i  (aw_addr),       .axi_aw_id_i    (aw_id),
        .axi_aw_len_i   (aw_len),        .axi_aw_burst_i (aw_burst),
        .axi_w_valid_i  (w_valid),       .axi_w_ready_o  (w_ready),
        .axi_w_data_i   (w_data),        .axi_w_last_i   (w_last),
        .axi_b_ready_i  (b_ready),       .axi_b_valid_o  (b_valid),
        .axi_b_resp_o   (b_resp),
        .axi_ar_valid_i (ar_valid),      .axi_ar_ready_o (ar_ready),
        .axi_ar_addr_i  (ar_addr),       .axi_ar_id_i    (ar_id),
        .axi_ar_len_i   (ar_len),        .axi_ar_burst_i (ar_burst),
        .axi_r_ready_i  (r_ready),       .axi_r_valid_o  (r_valid),
        .axi_r_data_o   (r_data),        .axi_r_last_o   (r_last),
        .axi_r_id_o     (r_id),          .axi_r_resp_o   (r_resp)
    );

endmodule

// ==== tests/mem_checker.sv ====
`timescale 1ns/1ps

module mem_checker (
    input  logic            aclk,
    input  logic            areset_n,
    input  logic            ifu_r_valid_i,
    input  mem_pkg::addr_t  ifu_r_addr_i,
    input  mem_pkg::len_t   ifu_r_len_i,
    input  logic            ifu_r_ready_i,
    input  mem_pkg::data_t  ifu_r_data_i,
    input  logic            ifu_r_last_i,
    input  logic            lsu_r_valid_i,
    input  mem_pkg::addr_t  lsu_r_addr_i,
    input  mem_pkg::len_t   lsu_r_len_i,
    input  logic            lsu_r_ready_i,
    input  mem_pkg::data_t  lsu_r_data_i,
    input  logic            lsu_r_last_i,
    input  logic            lsu_w_valid_i,
    input  mem_pkg::addr_t  lsu_w_addr_i,
    input  mem_pkg::len_t   lsu_w_len_i,
    input  mem_pkg::data_t  lsu_w_data_i,
    input  logic            lsu_w_ready_i,
    input  logic            lsu_w_last_i
);

    mem_pkg::data_t shadow [mem_pkg::SRAM_DEPTH];   // What the SRAM should hold
    string          test_name = "none";
    int             errors = 0;                     // Errors in the current test
    int             tests_passed = 0;
    int             tests_failed = 0;
    int             writes_done = 0;
    int             reads_done = 0;
    int             ifu_beat = 0;
    int             lsu_beat = 0;
    int             w_beat = 0;

    // Word k of a burst lives at (addr/8 + k) mod 256
    function automatic mem_pkg::idx_t word_index(input mem_pkg::addr_t addr, input int beat);
        return mem_pkg::idx_t'((addr / 8 + beat) % 256);
    endfunction

    function automatic mem_pkg::data_t expected_word(input mem_pkg::addr_t addr, input int beat);
        return shadow[word_index(addr, beat)];
    endfunction

    task automatic note_error(input string what);
        $display("ERROR in %s: %s", test_name, what);
        errors++;
    endtask

    task automatic check_read(input string port, input mem_pkg::addr_t addr,
                              input mem_pkg::len_t len, input int beat,
                              input mem_pkg::data_t data, input logic last);
        mem_pkg::data_t exp;
        exp = expected_word(addr, beat);
        if (data !== exp) begin
            $display("FAILED %s: %s beat %0d expected %h actual %h",
                     test_name, port, beat, exp, data);
            errors++;
        end
        if (last != (beat == int'(len))) begin
            note_error({port, " last flag does not mark the final beat"});
        end
    endtask

    always @(posedge aclk) begin
        if (areset_n) begin
            if ((ifu_r_ready_i || ifu_r_last_i) && !ifu_r_valid_i) begin
                note_error("ifu saw a read strobe with no request");
            end
            if ((lsu_r_ready_i || lsu_r_last_i) && !lsu_r_valid_i) begin
                note_error("lsu saw a read strobe with no request");
            end
            if ((lsu_w_ready_i || lsu_w_last_i) && !lsu_w_valid_i) begin
                note_error("lsu saw a write strobe with no request");
            end
            if (ifu_r_ready_i) begin
                check_read("ifu", ifu_r_addr_i, ifu_r_len_i, ifu_beat, ifu_r_data_i, ifu_r_last_i);
                ifu_beat = ifu_r_last_i ? 0 : ifu_beat + 1;
                if (ifu_r_last_i) reads_done++;
            end
            if (lsu_r_ready_i) begin
                check_read("lsu", lsu_r_addr_i, lsu_r_len_i, lsu_beat, lsu_r_data_i, lsu_r_last_i);
                lsu_beat = lsu_r_last_i ? 0 : lsu_beat + 1;
                if (lsu_r_last_i) reads_done++;
            end
            if (lsu_w_ready_i) begin
                if (w_beat > int'(lsu_w_len_i)) note_error("write took more beats than requested");
                shadow[word_index(lsu_w_addr_i, w_beat)] = lsu_w_data_i;
                w_beat++;
            end
            if (lsu_w_last_i) begin
                if (w_beat != int'(lsu_w_len_i) + 1) note_error("write ended before all beats moved");
                w_beat = 0;
                writes_done++;
            end
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        errors      = 0;
        writes_done = 0;
        reads_done  = 0;
    endtask

    task automatic finish_test(input int exp_writes, input int exp_reads);
        if (writes_done != exp_writes) begin
            $display("FAILED %s: write completions expected %0d actual %0d",
                     test_name, exp_writes, writes_done);
            errors++;
        end
        if (reads_done != exp_reads) begin
            $display("FAILED %s: read completions expected %0d actual %0d",
                     test_name, exp_reads, reads_done);
            errors++;
        end
        if (errors == 0) begin
            $display("Test %s passed", test_name);
            tests_passed++;
        end else begin
            $display("Test %s failed with %0d errors", test_name, errors);
            tests_failed++;
        end
    endtask

    task automatic print_totals();
        $display("Totals: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    endtask

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int TIMEOUT_CYCLES = 200;

    logic           aclk;
    logic           areset_n;
    logic           ifu_r_valid, ifu_r_ready, ifu_r_last;
    mem_pkg::addr_t ifu_r_addr;
    mem_pkg::len_t  ifu_r_len;
    mem_pkg::data_t ifu_r_data;
    logic           lsu_r_valid, lsu_r_ready, lsu_r_last;
    mem_pkg::addr_t lsu_r_addr;
    mem_pkg::len_t  lsu_r_len;
    mem_pkg::data_t lsu_r_data;
    logic           lsu_w_valid, lsu_w_ready, lsu_w_last;
    mem_pkg::addr_t lsu_w_addr;
    mem_pkg::len_t  lsu_w_len;
    mem_pkg::data_t lsu_w_data;
    int             writes_issued;
    int             reads_issued;

    mem_subsys_top DUT (
        .aclk          (aclk),        .areset_n      (areset_n),
        .ifu_r_valid_i (ifu_r_valid), .ifu_r_addr_i  (ifu_r_addr),
        .ifu_r_len_i   (ifu_r_len),   .ifu_r_ready_o (ifu_r_ready),
        .ifu_r_data_o  (ifu_r_data),  .ifu_r_last_o  (ifu_r_last),
        .lsu_r_valid_i (lsu_r_valid), .lsu_r_addr_i  (lsu_r_addr),
        .lsu_r_len_i   (lsu_r_len),   .lsu_r_ready_o (lsu_r_ready),
        .lsu_r_data_o  (lsu_r_data),  .lsu_r_last_o  (lsu_r_last),
        .lsu_w_valid_i (lsu_w_valid), .lsu_w_addr_i  (lsu_w_addr),
        .lsu_w_len_i   (lsu_w_len),   .lsu_w_data_i  (lsu_w_data),
        .lsu_w_ready_o (lsu_w_ready), .lsu_w_last_o  (lsu_w_last)
    );

    mem_checker u_checker (
        .aclk          (aclk),        .areset_n      (areset_n),
        .ifu_r_valid_i (ifu_r_valid), .ifu_r_addr_i  (ifu_r_addr),
        .ifu_r_len_i   (ifu_r_len),   .ifu_r_ready_i (ifu_r_ready),
        .ifu_r_data_i  (ifu_r_data),  .ifu_r_last_i  (ifu_r_last),
        .lsu_r_valid_i (lsu_r_valid), .lsu_r_addr_i  (lsu_r_addr),
        .lsu_r_len_i   (lsu_r_len),   .lsu_r_ready_i (lsu_r_ready),
        .lsu_r_data_i  (lsu_r_data),  .lsu_r_last_i  (lsu_r_last),
        .lsu_w_valid_i (lsu_w_valid), .lsu_w_addr_i  (lsu_w_addr),
        .lsu_w_len_i   (lsu_w_len),   .lsu_w_data_i  (lsu_w_data),
        .lsu_w_ready_i (lsu_w_ready), .lsu_w_last_i  (lsu_w_last)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    task automatic give_up(input string what);
        $display("timeout waiting for %s", what);
        u_checker.print_totals();
        $display("Some tests failed");
        $finish;
    endtask

    task automatic ifu_read(input mem_pkg::addr_t addr, input mem_pkg::len_t len);
        int cycles = 0;
        @(negedge aclk);
        ifu_r_valid = 1'b1;
        ifu_r_addr  = addr;
        ifu_r_len   = len;
        do begin
            @(negedge aclk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) give_up("the last ifu read beat");
        end while (!ifu_r_last);
        @(negedge aclk);                // Final beat moved on the edge before
        ifu_r_valid = 1'b0;
        reads_issued++;
    endtask

    task automatic lsu_read(input mem_pkg::addr_t addr, input mem_pkg::len_t len);
        int cycles = 0;
        @(negedge aclk);
        lsu_r_valid = 1'b1;
        lsu_r_addr  = addr;
        lsu_r_len   = len;
        do begin
            @(negedge aclk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) give_up("the last lsu read beat");
        end while (!lsu_r_last);
        @(negedge aclk);
        lsu_r_valid = 1'b0;
        reads_issued++;
    endtask

    task automatic lsu_write(input mem_pkg::addr_t addr, input mem_pkg::len_t len);
        mem_pkg::data_t beats [8];
        int             k = 0;
        int             cycles = 0;
        logic           sent = 1'b0;
        foreach (beats[i]) beats[i] = {$urandom, $urandom};
        @(negedge aclk);
        lsu_w_valid = 1'b1;
        lsu_w_addr  = addr;
        lsu_w_len   = len;
        lsu_w_data  = beats[0];
        do begin
            @(negedge aclk);
            if (sent) begin             // Previous beat was taken so the next one goes out
                k++;
                if (k <= int'(len)) lsu_w_data = beats[k[2:0]];
            end
            sent = lsu_w_ready;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) give_up("the lsu write response");
        end while (!lsu_w_last);
        @(negedge aclk);
        lsu_w_valid = 1'b0;
        writes_issued++;
    endtask

    task automatic begin_test(input string name);
        writes_issued = 0;
        reads_issued  = 0;
        u_checker.start_test(name);
    endtask

    task automatic end_test();
        u_checker.finish_test(writes_issued, reads_issued);
    endtask

    initial begin
        int             word;
        int             op;
        mem_pkg::addr_t addr;
        mem_pkg::len_t  len;
        void'($urandom(32'hec967ef2));
        areset_n    = 1'b0;
        ifu_r_valid = 1'b0;
        ifu_r_addr  = '0;
        ifu_r_len   = '0;
        lsu_r_valid = 1'b0;
        lsu_r_addr  = '0;
        lsu_r_len   = '0;
        lsu_w_valid = 1'b0;
        lsu_w_addr  = '0;
        lsu_w_len   = '0;
        lsu_w_data  = '0;
        writes_issued = 0;
        reads_issued  = 0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        areset_n = 1'b1;

        begin_test("reset_idle");
        repeat (12) @(negedge aclk);    // Any strobe here is flagged by the checker
        end_test();

        begin_test("single_write_read");
        lsu_write(32'h100, 8'd0);
        lsu_read(32'h100, 8'd0);
        end_test();

        begin_test("burst_write_ifu_read");
        lsu_write(32'h200, 8'd3);
        ifu_read(32'h200, 8'd3);
        end_test();

        begin_test("concurrent_reads");
        lsu_write(32'h400, 8'd3);
        lsu_write(32'h600, 8'd3);
        fork
            ifu_read(32'h400, 8'd3);
            lsu_read(32'h600, 8'd3);
        join
        end_test();

        begin_test("write_during_read");
        fork
            lsu_write(32'h300, 8'd5);
            ifu_read(32'h200, 8'd3);
        join
        lsu_read(32'h300, 8'd5);        // Words written under the read
        end_test();

        begin_test("random_mix");
        for (int i = 0; i < 8; i++) begin
            lsu_write(mem_pkg::addr_t'(i * 64), 8'd7);  // Fill words 0 to 63
        end
        for (int n = 0; n < 40; n++) begin
            op   = int'($urandom % 3);
            word = int'($urandom % 57);
            len  = mem_pkg::len_t'($urandom % 8);
            addr = ($urandom & 32'hFFFF_F800) | mem_pkg::addr_t'(word * 8);  // Upper bits alias
            case (op)
                0:       ifu_read(addr, len);
                1:       lsu_read(addr, len);
                default: lsu_write(addr, len);
            endcase
        end
        end_test();

        u_checker.print_totals();
        if (u_checker.tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/mem_pkg.sv
rtl/read_arbiter.sv
axi_master/axi_master.sv
axi_sram/axi_sram.sv
rtl/mem_subsys_top.sv
tests/mem_checker.sv
tests/tb_top.sv

// ==== Makefile ====
TOP := tb_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^All tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
